//--- common/coco_defines.svh
// CoCo bus widths and memory map
`ifndef COCO_DEFINES_SVH
`define COCO_DEFINES_SVH

// bus and storage widths
`define COCO_ADDR_W 16
`define COCO_DATA_W 8
`define COCO_RAM_AW 15  // 32 KB
`define COCO_ROM_AW 13  // 8 KB system banks
`define COCO_CART_AW 14 // 16 KB cartridge
`define COCO_LOAD_AW 17 // download address, bank index in 16:13

`define COCO_ROM_BANKS 10
`define COCO_RAM_BYTES (1 << `COCO_RAM_AW)
`define COCO_ROM_BANK_BYTES (1 << `COCO_ROM_AW)
`define COCO_CART_BYTES (1 << `COCO_CART_AW)

// returned for reads nothing drives
`define COCO_OPEN_BUS 8'hFF

// final download address must exceed this for a cart to count
`define COCO_CART_MIN_SIZE 17'd256

// region bases
`define COCO_ROM8_BASE 16'h8000 // extended basic
`define COCO_ROMA_BASE 16'hA000 // colour basic
`define COCO_ROMC_BASE 16'hC000 // cartridge / disk rom
`define COCO_PIA0_BASE 16'hFF00
`define COCO_PIA1_BASE 16'hFF20
`define COCO_IO_BASE 16'hFF40   // disk controller window
`define COCO_IO_END 16'hFF60

`endif

//--- common/cpu_bus_pkg.sv
// CPU side bus types
`include "coco_defines.svh"

package cpu_bus_pkg;

	typedef enum logic [2:0] {
		region_ram  = 3'd0,
		region_rom8 = 3'd1,
		region_roma = 3'd2,
		region_romc = 3'd3,
		region_pia0 = 3'd4,
		region_pia1 = 3'd5,
		region_io   = 3'd6,
		region_none = 3'd7
	} bus_region_t;

	// decoded request, offset is relative to the region base
	typedef struct packed {
		logic                    rd;
		logic                    wr;
		bus_region_t             region;
		logic [`COCO_ADDR_W-1:0] offset;
		logic [`COCO_DATA_W-1:0] wdata;
	} bus_req_t;

	typedef struct packed {
		logic                    valid;
		logic [`COCO_DATA_W-1:0] rdata;
	} bus_rsp_t;

	// every byte the select stage might return
	typedef struct packed {
		logic                    valid;
		bus_region_t             region;
		logic [`COCO_DATA_W-1:0] ram;
		logic [`COCO_DATA_W-1:0] sys_tandy;  // rom8 or romA, tandy image
		logic [`COCO_DATA_W-1:0] sys_dragon;
		logic [`COCO_DATA_W-1:0] alt1;       // dragon 64 bank 1
		logic [`COCO_DATA_W-1:0] alt2;       // dragon 64 bank 2
		logic [`COCO_DATA_W-1:0] disk;       // disk rom for current model
		logic [`COCO_DATA_W-1:0] cart;
	} mem_rd_t;

endpackage

//--- common/rom_image_pkg.sv
// ROM image and loader types
`include "coco_defines.svh"

package rom_image_pkg;

	// bank index, matches download address bits 16:13
	typedef enum logic [3:0] {
		romA_tandy  = 4'd0,
		rom8_tandy  = 4'd1,
		disk_tandy  = 4'd2,
		rom8_dragon = 4'd3,
		romA_dragon = 4'd4,
		rom8_d64_1  = 4'd5,
		romA_d64_1  = 4'd6,
		rom8_d64_2  = 4'd7,
		romA_d64_2  = 4'd8,
		disk_dragon = 4'd9
	} rom_image_t;

	typedef struct packed {
		logic                    rom_we;
		logic                    cart_we;
		rom_image_t              image;
		logic [`COCO_CART_AW-1:0] addr; // banks use the low 13 bits
		logic [`COCO_DATA_W-1:0] data;
	} rom_load_t;

	typedef struct packed {
		logic dragon;
		logic mem64kb;
		logic disk_cart_enabled;
		logic alt_bank; // dragon 64 rom bank bit from pia1
	} machine_cfg_t;

endpackage

//--- memory/dp_ram.sv
// Dual port synchronous RAM
`include "coco_defines.svh"

module dp_ram #(
	parameter int DEPTH_AW = 13
) (
	input  logic                    clk,
	input  logic [DEPTH_AW-1:0]     a_addr,
	input  logic                    a_we,
	input  logic [`COCO_DATA_W-1:0] a_wdata,
	output logic [`COCO_DATA_W-1:0] a_rdata,
	input  logic [DEPTH_AW-1:0]     b_addr,
	input  logic                    b_we,
	input  logic [`COCO_DATA_W-1:0] b_wdata
);

	logic [`COCO_DATA_W-1:0] mem [2**DEPTH_AW];

	// read first, port b wins a same address collision
	always_ff @(posedge clk) begin
		a_rdata <= mem[a_addr];
		if (a_we)
			mem[a_addr] <= a_wdata;
		if (b_we)
			mem[b_addr] <= b_wdata;
	end

endmodule

//--- memory/memory_array.sv
// RAM and ROM storage stage
`include "coco_defines.svh"

module memory_array import cpu_bus_pkg::*, rom_image_pkg::*; (
	input  logic         clk,
	input  logic         reset_n,
	input  machine_cfg_t cfg,
	input  bus_req_t     req,
	input  rom_load_t    load,
	output mem_rd_t      rd
);

	logic [`COCO_DATA_W-1:0] ram_q;
	logic [`COCO_DATA_W-1:0] cart_q;
	logic [`COCO_DATA_W-1:0] bank_q [`COCO_ROM_BANKS];
	logic                    ram_we;
	logic                    valid_q;
	bus_region_t             region_q;
	logic                    is_roma;

	assign ram_we = req.wr && (req.region == region_ram);

	// 32 KB ram, port b is not used by the loader
	dp_ram #(.DEPTH_AW(`COCO_RAM_AW)) u_ram (
		.clk,
		.a_addr(req.offset[`COCO_RAM_AW-1:0]),
		.a_we(ram_we),
		.a_wdata(req.wdata),
		.a_rdata(ram_q),
		.b_addr('0),
		.b_we(1'b0),
		.b_wdata('0)
	);

	// one 8 KB bank per image index
	for (genvar i = 0; i < `COCO_ROM_BANKS; i++) begin : g_bank
		dp_ram #(.DEPTH_AW(`COCO_ROM_AW)) u_bank (
			.clk,
			.a_addr(req.offset[`COCO_ROM_AW-1:0]),
			.a_we(1'b0),
			.a_wdata('0),
			.a_rdata(bank_q[i]),
			.b_addr(load.addr[`COCO_ROM_AW-1:0]),
			.b_we(load.rom_we && (load.image == rom_image_t'(i))),
			.b_wdata(load.data)
		);
	end

	dp_ram #(.DEPTH_AW(`COCO_CART_AW)) u_cart (
		.clk,
		.a_addr(req.offset[`COCO_CART_AW-1:0]),
		.a_we(1'b0),
		.a_wdata('0),
		.a_rdata(cart_q),
		.b_addr(load.addr),
		.b_we(load.cart_we),
		.b_wdata(load.data)
	);

	// region travels alongside the registered reads
	always_ff @(posedge clk) begin
		region_q <= req.region;
		if (!reset_n)
			valid_q <= 1'b0;
		else
			valid_q <= req.rd;
	end

	assign is_roma = (region_q == region_roma);

	always_comb begin
		rd.valid      = valid_q;
		rd.region     = region_q;
		rd.ram        = ram_q;
		rd.sys_tandy  = is_roma ? bank_q[romA_tandy] : bank_q[rom8_tandy];
		rd.sys_dragon = is_roma ? bank_q[romA_dragon] : bank_q[rom8_dragon];
		rd.alt1       = is_roma ? bank_q[romA_d64_1] : bank_q[rom8_d64_1];
		rd.alt2       = is_roma ? bank_q[romA_d64_2] : bank_q[rom8_d64_2];
		rd.disk       = cfg.dragon ? bank_q[disk_dragon] : bank_q[disk_tandy];
		rd.cart       = cart_q;
	end

endmodule

//--- rtl/bus_decode.sv
// Bus address decode stage
`include "coco_defines.svh"

module bus_decode import cpu_bus_pkg::*; (
	input  logic                    clk,
	input  logic                    reset_n,
	input  logic                    bus_rd,
	input  logic                    bus_wr,
	input  logic [`COCO_ADDR_W-1:0] bus_addr,
	input  logic [`COCO_DATA_W-1:0] bus_wdata,
	output bus_req_t                req
);

	bus_region_t             region_d;
	logic [`COCO_ADDR_W-1:0] base;

	// fixed memory map, no SAM mapping modes
	always_comb begin
		if (bus_addr < `COCO_ROM8_BASE) begin
			region_d = region_ram;
			base     = '0;
		end else if (bus_addr < `COCO_ROMA_BASE) begin
			region_d = region_rom8;
			base     = `COCO_ROM8_BASE;
		end else if (bus_addr < `COCO_ROMC_BASE) begin
			region_d = region_roma;
			base     = `COCO_ROMA_BASE;
		end else if (bus_addr < `COCO_PIA0_BASE) begin
			region_d = region_romc; // cart space runs up to the pias
			base     = `COCO_ROMC_BASE;
		end else if (bus_addr < `COCO_PIA1_BASE) begin
			region_d = region_pia0;
			base     = `COCO_PIA0_BASE;
		end else if (bus_addr < `COCO_IO_BASE) begin
			region_d = region_pia1;
			base     = `COCO_PIA1_BASE;
		end else if (bus_addr < `COCO_IO_END) begin
			region_d = region_io;
			base     = `COCO_IO_BASE;
		end else begin
			region_d = region_none;
			base     = '0;
		end
	end

	always_ff @(posedge clk) begin
		req.region <= region_d;
		req.offset <= bus_addr - base;
		req.wdata  <= bus_wdata;
		if (!reset_n) begin
			req.rd <= 1'b0;
			req.wr <= 1'b0;
		end else begin
			req.rd <= bus_rd;
			req.wr <= bus_wr; // rom writes pass, memory drops them
		end
	end

	// cpu issues one access per strobe
	a_rd_wr_excl: assert property (@(posedge clk) disable iff (!reset_n)
		!(bus_rd && bus_wr));

endmodule

//--- rtl/read_select.sv
// Read data select stage
`include "coco_defines.svh"

module read_select import cpu_bus_pkg::*, rom_image_pkg::*; (
	input  logic         clk,
	input  logic         reset_n,
	input  machine_cfg_t cfg,
	input  logic         cart_loaded,
	input  mem_rd_t      rd,
	output bus_rsp_t     rsp
);

	logic                    dragon64;
	logic [`COCO_DATA_W-1:0] sel;

	assign dragon64 = cfg.dragon & cfg.mem64kb;

	always_comb begin
		case (rd.region)
			region_ram:
				sel = rd.ram;
			region_rom8, region_roma: begin
				if (dragon64)
					sel = cfg.alt_bank ? rd.alt2 : rd.alt1;
				else
					sel = cfg.dragon ? rd.sys_dragon : rd.sys_tandy;
			end
			region_romc: begin
				if (cart_loaded)
					sel = rd.cart; // cartridge beats the disk rom
				else if (cfg.disk_cart_enabled)
					sel = rd.disk;
				else
					sel = `COCO_OPEN_BUS;
			end
			default:
				sel = `COCO_OPEN_BUS; // pias, io and unmapped
		endcase
	end

	always_ff @(posedge clk) begin
		rsp.rdata <= sel;
		if (!reset_n)
			rsp.valid <= 1'b0;
		else
			rsp.valid <= rd.valid;
	end

	// earlier stages must come out of reset empty
	a_quiet_after_reset: assert property (@(posedge clk)
		$rose(reset_n) |=> !rsp.valid);

endmodule

//--- rtl/rom_loader.sv
// ROM and cartridge download loader
`include "coco_defines.svh"

module rom_loader import rom_image_pkg::*; (
	input  logic                     clk,
	input  logic                     reset_n,
	input  logic                     load_wr,
	input  logic                     load_rom,
	input  logic                     load_cart,
	input  logic                     load_download,
	input  logic                     cart_remove,
	input  logic [`COCO_LOAD_AW-1:0] load_addr,
	input  logic [`COCO_DATA_W-1:0]  load_data,
	output rom_load_t                load,
	output logic                     cart_loaded
);

	logic image_ok;

	// only indices 0..9 have a bank
	assign image_ok = (load_addr[16:13] < 4'(`COCO_ROM_BANKS));

	always_ff @(posedge clk) begin
		load.image <= rom_image_t'(load_addr[16:13]);
		load.addr  <= load_addr[`COCO_CART_AW-1:0];
		load.data  <= load_data;
		if (!reset_n) begin
			load.rom_we  <= 1'b0;
			load.cart_we <= 1'b0;
		end else begin
			load.rom_we  <= load_wr & load_rom & image_ok;
			load.cart_we <= load_wr & load_cart;
		end
	end

	// address sampled between writes, so the last one marks the size
	always_ff @(posedge clk) begin
		if (!reset_n)
			cart_loaded <= 1'b0;
		else if (load_cart & load_download & ~load_wr)
			cart_loaded <= (load_addr > `COCO_CART_MIN_SIZE);
		else if (cart_remove)
			cart_loaded <= 1'b0;
	end

	// downloader never targets rom and cart at once
	a_one_target: assert property (@(posedge clk) disable iff (!reset_n)
		!(load.rom_we && load.cart_we));

endmodule

//--- rtl/coco_rom_bus.sv
// CoCo / Dragon ROM read path
`include "coco_defines.svh"

module coco_rom_bus import cpu_bus_pkg::*, rom_image_pkg::*; (
	input  logic                     clk,
	input  logic                     reset_n,
	input  machine_cfg_t             cfg,
	input  logic                     load_wr,
	input  logic                     load_rom,
	input  logic                     load_cart,
	input  logic                     load_download,
	input  logic                     cart_remove,
	input  logic [`COCO_LOAD_AW-1:0] load_addr,
	input  logic [`COCO_DATA_W-1:0]  load_data,
	input  logic                     bus_rd,
	input  logic                     bus_wr,
	input  logic [`COCO_ADDR_W-1:0]  bus_addr,
	input  logic [`COCO_DATA_W-1:0]  bus_wdata,
	output logic                     rd_valid,
	output logic [`COCO_DATA_W-1:0]  rd_data
);

	rom_load_t load;
	logic      cart_loaded;
	bus_req_t  req;
	mem_rd_t   mem_rd;
	bus_rsp_t  rsp;

	rom_loader u_loader (
		.clk,
		.reset_n,
		.load_wr,
		.load_rom,
		.load_cart,
		.load_download,
		.cart_remove,
		.load_addr,
		.load_data,
		.load,
		.cart_loaded
	);

	bus_decode u_decode (
		.clk,
		.reset_n,
		.bus_rd,
		.bus_wr,
		.bus_addr,
		.bus_wdata,
		.req
	);

	memory_array u_mem (.clk, .reset_n, .cfg, .req, .load, .rd(mem_rd));

	read_select u_select (.clk, .reset_n, .cfg, .cart_loaded, .rd(mem_rd), .rsp);

	assign rd_valid = rsp.valid;
	assign rd_data  = rsp.rdata;

endmodule

//--- testbench/tb_model.svh
// Read path reference model
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// mirrors of everything a read can return
logic [7:0]  img_m [10][8192];   // system banks by image index
logic [7:0]  cart_m [16384];
logic [7:0]  ram_m [32768];
logic        cart_loaded_m;
logic [31:0] rng_state = 32'had8c_bee2;

function automatic logic [31:0] next_rand();
	logic [31:0] x;
	x = rng_state;
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	rng_state = x;
	return x;
endfunction

// kind 1 is rom8/romA, kind 2 is cart space, else anywhere with extra FFxx hits
function automatic logic [15:0] pick_addr(input int kind);
	logic [31:0] r;
	r = next_rand();
	case (kind)
		1:
			return {2'b10, r[13:0]};
		2:
			return 16'hC000 + (r[15:0] % 16'h3F00);
		default:
			return (r[2:0] == 3'd0) ? {8'hFF, r[15:8]} : r[31:16];
	endcase
endfunction

// memory map plus the select rule for the returned byte
function automatic logic [7:0] expect_byte(input logic [15:0] addr, input machine_cfg_t c);
	logic [15:0] off;
	logic [3:0]  idx;
	logic        roma;
	off  = addr - 16'hC000;
	roma = (addr >= 16'hA000);
	if (c.dragon && c.mem64kb)
		idx = c.alt_bank ? (roma ? 4'd8 : 4'd7) : (roma ? 4'd6 : 4'd5);
	else if (c.dragon)
		idx = roma ? 4'd4 : 4'd3;
	else
		idx = roma ? 4'd0 : 4'd1;
	if (addr < 16'h8000)
		return ram_m[addr[14:0]];
	else if (addr < 16'hC000)
		return img_m[idx][addr[12:0]];
	else if (addr >= 16'hFF00)
		return 8'hFF; // pia0, pia1, disk io, unmapped
	else if (cart_loaded_m)
		return cart_m[off[13:0]];
	else if (c.disk_cart_enabled)
		return img_m[c.dragon ? 4'd9 : 4'd2][off[12:0]];
	else
		return 8'hFF;
endfunction

`endif

//--- testbench/tb_coco_rom_bus.sv
// CoCo ROM bus testbench
module tb_coco_rom_bus import rom_image_pkg::*;;
	timeunit 1ns;
	timeprecision 1ps;

	logic         clk;
	logic         reset_n;
	machine_cfg_t cfg;
	logic         load_wr;
	logic         load_rom;
	logic         load_cart;
	logic         load_download;
	logic         cart_remove;
	logic [16:0]  load_addr;
	logic [7:0]   load_data;
	logic         bus_rd;
	logic         bus_wr;
	logic [15:0]  bus_addr;
	logic [7:0]   bus_wdata;
	logic         rd_valid;
	logic [7:0]   rd_data;
	logic [31:0]  cycle = 32'd0;

	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  data;
		logic [31:0] issue_cycle;
	} exp_t;

	exp_t exp_q [$];

	`include "tb_model.svh"

	coco_rom_bus DUT (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk)
		cycle <= cycle + 32'd1;

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("tests failed");
		$fatal(1, "stopping at first error");
	endtask

	// all strobes drop unless the caller raises them again
	task automatic next_cycle();
		@(posedge clk);
		#1;
		bus_rd        = 1'b0;
		bus_wr        = 1'b0;
		load_wr       = 1'b0;
		load_rom      = 1'b0;
		load_cart     = 1'b0;
		load_download = 1'b0;
		cart_remove   = 1'b0;
	endtask

	task automatic bus_access(input logic wr, input logic [15:0] addr, input logic [7:0] data);
		exp_t e;
		next_cycle();
		bus_rd    = !wr;
		bus_wr    = wr;
		bus_addr  = addr;
		bus_wdata = data;
		if (wr && addr < 16'h8000)
			ram_m[addr[14:0]] = data;
		else if (!wr) begin
			e.addr        = addr;
			e.data        = expect_byte(addr, cfg);
			e.issue_cycle = cycle;
			exp_q.push_back(e);
		end
	endtask

	task automatic load_byte(input logic cart, input logic [16:0] addr, input logic [7:0] data);
		next_cycle();
		load_wr       = 1'b1;
		load_rom      = !cart;
		load_cart     = cart;
		load_download = 1'b1;
		load_addr     = addr;
		load_data     = data;
		if (cart)
			cart_m[addr[13:0]] = data;
		else if (addr[16:13] < 4'd10)
			img_m[addr[16:13]][addr[12:0]] = data; // index 10..15 has no bank
	endtask

	// idle download cycle whose address sets the cartridge size
	task automatic end_cart_download(input logic [16:0] addr);
		next_cycle();
		load_cart     = 1'b1;
		load_download = 1'b1;
		load_addr     = addr;
		cart_loaded_m = (addr > 17'd256);
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		while (exp_q.size() != 0 && waited < 10) begin
			next_cycle();
			waited++;
		end
		assert (exp_q.size() == 0)
			else stop_on_error("reads still outstanding after 10 idle cycles");
	endtask

	task automatic set_cfg(input machine_cfg_t c);
		drain();
		cfg = c;
	endtask

	// compare each response with the oldest queued read
	always @(negedge clk) begin
		exp_t e;
		if (reset_n && rd_valid) begin
			assert (exp_q.size() > 0)
				else stop_on_error("response arrived with no read outstanding");
			e = exp_q.pop_front();
			assert (cycle == e.issue_cycle + 32'd3) else stop_on_error($sformatf(
				"response for addr %h came %0d cycles after its read", e.addr, cycle - e.issue_cycle));
			assert (rd_data == e.data) else stop_on_error($sformatf(
				"ERR rd_data addr=%h exp=%h got=%h", e.addr, e.data, rd_data));
		end else if (reset_n && exp_q.size() > 0) begin
			assert (cycle <= exp_q[0].issue_cycle + 32'd3) else stop_on_error($sformatf(
				"no response for the read of addr %h", exp_q[0].addr));
		end
	end

	initial begin
		logic [31:0] r;
		reset_n       = 1'b0;
		cfg           = '0;
		load_wr       = 1'b0;
		load_rom      = 1'b0;
		load_cart     = 1'b0;
		load_download = 1'b0;
		cart_remove   = 1'b0;
		load_addr     = '0;
		load_data     = '0;
		bus_rd        = 1'b0;
		bus_wr        = 1'b0;
		bus_addr      = '0;
		bus_wdata     = '0;
		cart_loaded_m = 1'b0;
		repeat (5) next_cycle();
		reset_n = 1'b1;

		repeat (10) begin
			next_cycle();
			assert (!rd_valid)
				else stop_on_error($sformatf("ERR rd_valid exp=0 got=%h", rd_valid));
		end

		// fill ram, all banks and the cartridge
		for (int a = 0; a < 32768; a++) begin
			r = next_rand();
			bus_access(1'b1, a[15:0], r[7:0]);
		end
		for (int a = 0; a < 10 * 8192; a++) begin
			r = next_rand();
			load_byte(1'b0, a[16:0], r[7:0]);
		end
		for (int a = 0; a < 16; a++)
			load_byte(1'b0, {4'd12, a[12:0]}, 8'h5A);
		for (int a = 0; a < 16384; a++) begin
			r = next_rand();
			load_byte(1'b1, a[16:0], r[7:0]);
		end
		end_cart_download(17'd256); // too small to set the flag

		for (int c = 0; c < 16; c++) begin
			set_cfg(machine_cfg_t'(c[3:0]));
			repeat (300) bus_access(1'b0, pick_addr(0), 8'h00);
			repeat (60) bus_access(1'b0, pick_addr(2), 8'h00);
		end

		// dragon 64 bank switching between bursts
		for (int k = 0; k < 6; k++) begin
			set_cfg(machine_cfg_t'({2'b11, k[1], k[0]}));
			repeat (100) bus_access(1'b0, pick_addr(1), 8'h00);
		end

		set_cfg(machine_cfg_t'(4'b1010));
		repeat (3000) begin
			r = next_rand();
			case (r[1:0])
				2'd0:
					bus_access(1'b1, {8'h01, r[15:8]}, r[23:16]);
				2'd1:
					bus_access(1'b1, 16'h8000 | r[31:16], r[23:16]); // memory drops it
				default:
					bus_access(1'b0, r[2] ? {8'h01, r[15:8]} : pick_addr(1), 8'h00);
			endcase
		end

		set_cfg(machine_cfg_t'(4'b0000));
		end_cart_download(17'h0_4000);
		for (int c = 0; c < 4; c++) begin
			set_cfg(machine_cfg_t'({c[0], 1'b0, c[1], 1'b0}));
			repeat (100) bus_access(1'b0, pick_addr(2), 8'h00);
		end
		drain();
		next_cycle();
		cart_remove   = 1'b1;
		cart_loaded_m = 1'b0;
		for (int c = 0; c < 4; c++) begin
			set_cfg(machine_cfg_t'({c[0], 1'b0, c[1], 1'b0}));
			repeat (100) bus_access(1'b0, pick_addr(2), 8'h00);
		end
		drain();

		$display("all tests passed");
		$finish;
	end

endmodule

//--- sim.f
+incdir+common
+incdir+testbench
common/cpu_bus_pkg.sv
common/rom_image_pkg.sv
memory/dp_ram.sv
memory/memory_array.sv
rtl/bus_decode.sv
rtl/read_select.sv
rtl/rom_loader.sv
rtl/coco_rom_bus.sv
testbench/tb_coco_rom_bus.sv

//--- run.sh
#!/bin/sh
# compile with Verilator and run the testbench
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f sim.f \
	--top-module tb_coco_rom_bus \
	-o tb_coco_rom_bus

out=$(./obj_dir/tb_coco_rom_bus 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "all tests passed"; then
	exit 0
else
	exit 1
fi
